// File: compile.f
+incdir+design
design/video_pkg.sv
design/mem_pkg.sv
design/mem_port_if.sv
design/frame_writer.sv
design/frame_reader.sv
design/mem_arbiter.sv
design/ctrl_regs.sv
design/frame_buf_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/tb_frame_buf.sv

// File: design/ctrl_regs.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module ctrl_regs
  import video_pkg::*;
  import mem_pkg::*;
(
  input  logic                      clk_board,
  input  logic                      rst_n_i,
  input  logic [`FB_AXI_ADDR_W-1:0] awaddr_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [`FB_WORD_W-1:0]     wdata_i,
  input  logic [`FB_WORD_W/8-1:0]   wstrb_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  output logic [1:0]                bresp_o,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  input  logic [`FB_AXI_ADDR_W-1:0] araddr_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  output logic [`FB_WORD_W-1:0]     rdata_o,
  output logic [1:0]                rresp_o,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  input  logic                      frame_done_i,
  input  frm_len_t                  frame_len_i,
  input  logic                      play_busy_i,
  output logic                      cap_en_o,
  output logic                      play_start_o,
  output luma_t                     luma_o
);

  logic                  wr_acc;
  logic                  rd_acc;
  logic [15:0]           frm_cnt_q;
  logic [`FB_WORD_W-1:0] rd_mux;

  // Address and data taken together, one at a time
  assign wr_acc    = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign bresp_o   = 2'b00;

  assign rd_acc    = arvalid_i && !rvalid_o;
  assign arready_o = rd_acc;
  assign rresp_o   = 2'b00;

  //========================================
  // Register map
  //========================================
  always_comb begin
    rd_mux = '0;
    case (araddr_i)
      `FB_REG_CTRL:   rd_mux[1:0] = {play_busy_i, cap_en_o};
      `FB_REG_LUMA:   rd_mux[`FB_PIX_W-1:0] = luma_o;
      `FB_REG_STATUS: rd_mux = {5'b0, frame_len_i, frm_cnt_q};
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_board or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cap_en_o     <= 1'b0;
      play_start_o <= 1'b0;
      luma_o       <= '0;
      frm_cnt_q    <= '0;
      bvalid_o     <= 1'b0;
      rvalid_o     <= 1'b0;
    end else begin
      play_start_o <= 1'b0;
      // Writable fields all sit in byte lane 0
      if (wr_acc && wstrb_i[0]) begin
        case (awaddr_i)
          `FB_REG_CTRL: begin
            cap_en_o     <= wdata_i[0];
            play_start_o <= wdata_i[1];
          end
          `FB_REG_LUMA: luma_o <= wdata_i[`FB_PIX_W-1:0];
          default: ;
        endcase
      end
      if (frame_done_i) begin
        frm_cnt_q <= frm_cnt_q + 1'b1;
      end
      if (wr_acc) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_acc) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_board) begin
    if (rd_acc) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

// File: design/fb_macros.svh
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// Frame memory geometry
`define FB_DEPTH_WORDS 256
`define FB_PIX_W       8
`define FB_WORD_W      32

// AXI4-Lite register map
`define FB_AXI_ADDR_W  4
`define FB_REG_CTRL    4'h0
`define FB_REG_LUMA    4'h4
`define FB_REG_STATUS  4'h8

`endif

// File: design/frame_buf_top.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module frame_buf_top
  import video_pkg::*;
  import mem_pkg::*;
(
  input  logic                      clk_board,
  input  logic                      rst_n_i,
  // Camera byte stream
  input  logic                      cam_vld_i,
  input  pix_t                      cam_data_i,
  input  logic                      cam_sof_i,
  input  logic                      cam_eof_i,
  // AXI4-Lite slave
  input  logic [`FB_AXI_ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                      s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  logic [`FB_WORD_W-1:0]     s_axi_wdata_i,
  input  logic [`FB_WORD_W/8-1:0]   s_axi_wstrb_i,
  input  logic                      s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  output logic [1:0]                s_axi_bresp_o,
  output logic                      s_axi_bvalid_o,
  input  logic                      s_axi_bready_i,
  input  logic [`FB_AXI_ADDR_W-1:0] s_axi_araddr_i,
  input  logic                      s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output logic [`FB_WORD_W-1:0]     s_axi_rdata_o,
  output logic [1:0]                s_axi_rresp_o,
  output logic                      s_axi_rvalid_o,
  input  logic                      s_axi_rready_i,
  // Playback byte stream
  output logic                      out_vld_o,
  input  logic                      out_rdy_i,
  output pix_t                      out_data_o,
  output logic                      out_sof_o,
  output logic                      out_eof_o
);

  frm_len_t frame_len;
  logic     frame_done;
  logic     cap_en;
  logic     play_start;
  logic     play_busy;
  luma_t    luma;

  mem_port_if wr_port ();
  mem_port_if rd_port ();

  //========================================
  // Capture and playback peers
  //========================================
  frame_writer u_frame_writer (
    .clk_board    (clk_board),
    .rst_n_i      (rst_n_i),
    .cam_vld_i    (cam_vld_i),
    .cam_data_i   (cam_data_i),
    .cam_sof_i    (cam_sof_i),
    .cam_eof_i    (cam_eof_i),
    .cap_en_i     (cap_en),
    .mem          (wr_port.requester),
    .frame_len_o  (frame_len),
    .frame_done_o (frame_done)
  );

  frame_reader u_frame_reader (
    .clk_board    (clk_board),
    .rst_n_i      (rst_n_i),
    .play_start_i (play_start),
    .frame_len_i  (frame_len),
    .luma_i       (luma),
    .mem          (rd_port.requester),
    .out_vld_o    (out_vld_o),
    .out_rdy_i    (out_rdy_i),
    .out_data_o   (out_data_o),
    .out_sof_o    (out_sof_o),
    .out_eof_o    (out_eof_o),
    .play_busy_o  (play_busy)
  );

  mem_arbiter u_mem_arbiter (
    .clk_board (clk_board),
    .rst_n_i   (rst_n_i),
    .wr_port   (wr_port.arbiter),
    .rd_port   (rd_port.arbiter)
  );

  //========================================
  // Register block
  //========================================
  ctrl_regs u_ctrl_regs (
    .clk_board    (clk_board),
    .rst_n_i      (rst_n_i),
    .awaddr_i     (s_axi_awaddr_i),
    .awvalid_i    (s_axi_awvalid_i),
    .awready_o    (s_axi_awready_o),
    .wdata_i      (s_axi_wdata_i),
    .wstrb_i      (s_axi_wstrb_i),
    .wvalid_i     (s_axi_wvalid_i),
    .wready_o     (s_axi_wready_o),
    .bresp_o      (s_axi_bresp_o),
    .bvalid_o     (s_axi_bvalid_o),
    .bready_i     (s_axi_bready_i),
    .araddr_i     (s_axi_araddr_i),
    .arvalid_i    (s_axi_arvalid_i),
    .arready_o    (s_axi_arready_o),
    .rdata_o      (s_axi_rdata_o),
    .rresp_o      (s_axi_rresp_o),
    .rvalid_o     (s_axi_rvalid_o),
    .rready_i     (s_axi_rready_i),
    .frame_done_i (frame_done),
    .frame_len_i  (frame_len),
    .play_busy_i  (play_busy),
    .cap_en_o     (cap_en),
    .play_start_o (play_start),
    .luma_o       (luma)
  );

endmodule

// File: design/frame_reader.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module frame_reader
  import video_pkg::*;
  import mem_pkg::*;
(
  input  logic           clk_board,
  input  logic           rst_n_i,
  input  logic           play_start_i,
  input  frm_len_t       frame_len_i,
  input  luma_t          luma_i,
  mem_port_if.requester  mem,
  output logic           out_vld_o,
  input  logic           out_rdy_i,
  output pix_t           out_data_o,
  output logic           out_sof_o,
  output logic           out_eof_o,
  output logic           play_busy_o
);

  rd_state_e          state_q;
  mem_addr_t          addr_q;
  frm_len_t           fetch_left_q;
  frm_len_t           out_left_q;
  luma_t              luma_q;
  mem_word_t          nxt_q;
  logic               nxt_vld_q;
  mem_word_t          ubuf_q;
  logic               uvld_q;
  byte_sel_t          ulane_q;
  logic               first_q;
  logic               xfer;
  logic               last_byte;
  logic               word_done;
  logic               load;
  pix_t               pix;
  logic [`FB_PIX_W:0] sum;

  //========================================
  // Fetch side
  //========================================
  // No new read while one is outstanding or the next word waits
  assign mem.req   = (state_q == FETCH) && !nxt_vld_q && !mem.rvalid;
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  assign xfer      = uvld_q && out_rdy_i;
  assign last_byte = (out_left_q == frm_len_t'(1));
  assign word_done = xfer && ((ulane_q == 2'd3) || last_byte);
  assign load      = nxt_vld_q && (!uvld_q || word_done);

  //========================================
  // Output side
  //========================================
  assign pix         = ubuf_q[ulane_q*`FB_PIX_W +: `FB_PIX_W];
  assign sum         = {1'b0, pix} + {1'b0, luma_q};
  // Clip at full scale
  assign out_data_o  = sum[`FB_PIX_W] ? '1 : sum[`FB_PIX_W-1:0];
  assign out_vld_o   = uvld_q;
  assign out_sof_o   = uvld_q && first_q;
  assign out_eof_o   = uvld_q && last_byte;
  assign play_busy_o = (state_q != IDLE);

  always_ff @(posedge clk_board or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      addr_q       <= '0;
      fetch_left_q <= '0;
      out_left_q   <= '0;
      nxt_vld_q    <= 1'b0;
      uvld_q       <= 1'b0;
      ulane_q      <= '0;
      first_q      <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (play_start_i && (frame_len_i != '0)) begin
            state_q      <= FETCH;
            addr_q       <= '0;
            fetch_left_q <= frame_len_i;
            out_left_q   <= frame_len_i;
            first_q      <= 1'b1;
          end
        end
        FETCH: begin
          if (mem.req && mem.gnt) begin
            addr_q <= addr_q + 1'b1;
            if (fetch_left_q <= frm_len_t'(4)) begin
              fetch_left_q <= '0;
              state_q      <= DRAIN;
            end else begin
              fetch_left_q <= fetch_left_q - frm_len_t'(4);
            end
          end
        end
        DRAIN: begin
          if (xfer && last_byte) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase

      // Unpack register, low byte first
      if (xfer) begin
        out_left_q <= out_left_q - 1'b1;
        first_q    <= 1'b0;
        ulane_q    <= ulane_q + 1'b1;
      end
      if (word_done) begin
        uvld_q <= 1'b0;
      end
      if (load) begin
        uvld_q    <= 1'b1;
        ulane_q   <= '0;
        nxt_vld_q <= 1'b0;
      end
      if (mem.rvalid) begin
        nxt_vld_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_board) begin
    if (mem.rvalid) begin
      nxt_q <= mem.rdata;
    end
    if (load) begin
      ubuf_q <= nxt_q;
    end
    // Offset held for the whole frame
    if ((state_q == IDLE) && play_start_i) begin
      luma_q <= luma_i;
    end
  end

endmodule

// File: design/frame_writer.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module frame_writer
  import video_pkg::*;
  import mem_pkg::*;
(
  input  logic           clk_board,
  input  logic           rst_n_i,
  input  logic           cam_vld_i,
  input  pix_t           cam_data_i,
  input  logic           cam_sof_i,
  input  logic           cam_eof_i,
  input  logic           cap_en_i,
  mem_port_if.requester  mem,
  output frm_len_t       frame_len_o,
  output logic           frame_done_o
);

  logic      active_q;
  logic      take;
  logic      req_q;
  byte_sel_t lane_q;
  byte_sel_t cur_lane;
  mem_word_t word_q;
  mem_addr_t addr_q;
  frm_len_t  cnt_q;
  frm_len_t  cnt_nxt;

  // A frame is kept only if capture was enabled at its sof
  assign take     = cam_vld_i && (cam_sof_i ? cap_en_i : active_q);
  assign cur_lane = cam_sof_i ? byte_sel_t'(0) : lane_q;
  assign cnt_nxt  = cam_sof_i ? frm_len_t'(1) : cnt_q + 1'b1;

  assign mem.req   = req_q;
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_q;
  assign mem.wdata = word_q;

  always_ff @(posedge clk_board or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q     <= 1'b0;
      req_q        <= 1'b0;
      lane_q       <= '0;
      addr_q       <= '0;
      cnt_q        <= '0;
      frame_len_o  <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= 1'b0;
      if (req_q && mem.gnt) begin
        req_q  <= 1'b0;
        addr_q <= addr_q + 1'b1;
      end
      if (cam_vld_i && cam_sof_i) begin
        active_q <= cap_en_i;
      end
      if (take) begin
        cnt_q  <= cnt_nxt;
        lane_q <= cur_lane + 1'b1;
        // New frame restarts at word zero
        if (cam_sof_i) begin
          addr_q <= '0;
        end
        if ((cur_lane == 2'd3) || cam_eof_i) begin
          req_q <= 1'b1;
        end
        if (cam_eof_i) begin
          active_q     <= 1'b0;
          lane_q       <= '0;
          frame_len_o  <= cnt_nxt;
          frame_done_o <= 1'b1;
        end
      end
    end
  end

  // Little-endian packing, lane 0 clears the rest so a short word is zero padded
  always_ff @(posedge clk_board) begin
    if (take) begin
      if (cur_lane == 2'd0) begin
        word_q <= mem_word_t'(cam_data_i);
      end else begin
        word_q[cur_lane*`FB_PIX_W +: `FB_PIX_W] <= cam_data_i;
      end
    end
  end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module mem_arbiter
  import mem_pkg::*;
(
  input  logic          clk_board,
  input  logic          rst_n_i,
  mem_port_if.arbiter   wr_port,
  mem_port_if.arbiter   rd_port
);

  grant_e    grant;
  mem_addr_t addr;
  mem_word_t wdata;
  logic      we;
  mem_word_t rdata_q;
  logic      wr_rvld_q;
  logic      rd_rvld_q;
  mem_word_t frame_mem [`FB_DEPTH_WORDS];

  // Fixed priority, capture first
  always_comb begin
    if (wr_port.req) begin
      grant = WRITER;
    end else if (rd_port.req) begin
      grant = READER;
    end else begin
      grant = NONE;
    end
  end

  assign wr_port.gnt = (grant == WRITER);
  assign rd_port.gnt = (grant == READER);

  assign addr  = (grant == WRITER) ? wr_port.addr  : rd_port.addr;
  assign wdata = (grant == WRITER) ? wr_port.wdata : rd_port.wdata;
  assign we    = (grant == WRITER) ? wr_port.we    : (grant == READER) && rd_port.we;

  //========================================
  // Single-port frame memory
  //========================================
  always_ff @(posedge clk_board) begin
    if (we) begin
      frame_mem[addr] <= wdata;
    end
    rdata_q <= frame_mem[addr];
  end

  // Read data goes back to whichever port was granted a read
  always_ff @(posedge clk_board or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_rvld_q <= 1'b0;
      rd_rvld_q <= 1'b0;
    end else begin
      wr_rvld_q <= wr_port.gnt && !wr_port.we;
      rd_rvld_q <= rd_port.gnt && !rd_port.we;
    end
  end

  assign wr_port.rvalid = wr_rvld_q;
  assign wr_port.rdata  = rdata_q;
  assign rd_port.rvalid = rd_rvld_q;
  assign rd_port.rdata  = rdata_q;

endmodule

// File: design/mem_pkg.sv
`include "fb_macros.svh"

package mem_pkg;

  typedef logic [`FB_WORD_W-1:0] mem_word_t;
  typedef logic [$clog2(`FB_DEPTH_WORDS)-1:0] mem_addr_t;

  // Bytes per frame, one extra bit so a full memory fits
  typedef logic [$clog2(`FB_DEPTH_WORDS*`FB_WORD_W/`FB_PIX_W):0] frm_len_t;

  // Who owns the memory this cycle
  typedef enum logic [1:0] {
    NONE,
    WRITER,
    READER
  } grant_e;

endpackage

// File: design/mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if
  import mem_pkg::*;
();

  // Request side
  logic      req;
  logic      we;
  mem_addr_t addr;
  mem_word_t wdata;

  // Response side, rvalid one cycle after req and gnt
  logic      gnt;
  logic      rvalid;
  mem_word_t rdata;

  modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata);

  modport arbiter (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

// File: design/video_pkg.sv
`include "fb_macros.svh"

package video_pkg;

  // One camera or output byte
  typedef logic [`FB_PIX_W-1:0] pix_t;

  // Unsigned brightness offset
  typedef logic [`FB_PIX_W-1:0] luma_t;

  // Byte lane inside a memory word
  typedef logic [1:0] byte_sel_t;

  // Playback FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DRAIN
  } rd_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_frame_buf \
  -f compile.f -o sim_frame_buf \
  && ./obj_dir/sim_frame_buf | tee /dev/stderr | grep -F -- '** PASS **' > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
  import video_pkg::*;
(
  input  logic        clk_board,
  input  logic        rst_n_i,
  // DUT output stream
  input  logic        out_vld_i,
  input  logic        out_rdy_i,
  input  pix_t        out_data_i,
  input  logic        out_sof_i,
  input  logic        out_eof_i,
  // AXI4-Lite requests
  input  logic        awvalid_i,
  input  logic        awready_i,
  input  logic        wvalid_i,
  input  logic        wready_i,
  input  logic        arvalid_i,
  input  logic        arready_i,
  // AXI4-Lite responses
  input  logic        bvalid_i,
  input  logic        bready_i,
  input  logic [1:0]  bresp_i,
  input  logic        rvalid_i,
  input  logic        rready_i,
  input  logic [1:0]  rresp_i,
  input  logic [31:0] rdata_i,
  // Expected values from the stimulus side
  input  logic        exp_push_i,
  input  logic [9:0]  exp_byte_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        row_done_i,
  input  int          row_idx_i,
  input  logic        fin_i,
  output int          err_cnt_o,
  output int          chk_cnt_o,
  output int          pend_o
);

  // Each entry is {sof, eof, data}
  logic [9:0] exp_q[$];
  logic [9:0] exp_w;
  int         pushed_q;
  int         popped_q;
  int         row_err_q;
  int         row_chk_q;
  logic       wr_pend_q;
  logic       rd_pend_q;
  logic       wr_take;
  logic       rd_take;

  assign pend_o = pushed_q - popped_q;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt_o = chk_cnt_o + 1;
    if (got !== exp) begin
      err_cnt_o = err_cnt_o + 1;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  always @(posedge clk_board or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      pushed_q  = 0;
      popped_q  = 0;
      row_err_q = 0;
      row_chk_q = 0;
      wr_pend_q = 1'b0;
      rd_pend_q = 1'b0;
    end else begin
      if (exp_push_i) begin
        exp_q.push_back(exp_byte_i);
        pushed_q = pushed_q + 1;
      end
      //========================================
      // Output stream
      //========================================
      // One expected entry per transfer
      if (out_vld_i && out_rdy_i) begin
        if (exp_q.size() == 0) begin
          err_cnt_o = err_cnt_o + 1;
          $display("Output byte 0x%h arrived when no byte was expected", out_data_i);
        end else begin
          exp_w    = exp_q.pop_front();
          popped_q = popped_q + 1;
          compare("out_data_o", {24'h0, out_data_i}, {24'h0, exp_w[7:0]});
          compare("out_sof_o", {31'h0, out_sof_i}, {31'h0, exp_w[9]});
          compare("out_eof_o", {31'h0, out_eof_i}, {31'h0, exp_w[8]});
        end
      end
      //========================================
      // AXI4-Lite handshakes
      //========================================
      // A request is taken only while no response of its kind is pending
      wr_take = awvalid_i && wvalid_i && !wr_pend_q;
      rd_take = arvalid_i && !rd_pend_q;
      if (wr_take || awready_i || wready_i) begin
        compare("s_axi_awready_o", {31'h0, awready_i}, {31'h0, wr_take});
        compare("s_axi_wready_o", {31'h0, wready_i}, {31'h0, wr_take});
      end
      if (rd_take || arready_i) begin
        compare("s_axi_arready_o", {31'h0, arready_i}, {31'h0, rd_take});
      end
      // Response held from the cycle after the request until taken
      if (wr_pend_q || bvalid_i) begin
        compare("s_axi_bvalid_o", {31'h0, bvalid_i}, {31'h0, wr_pend_q});
      end
      if (rd_pend_q || rvalid_i) begin
        compare("s_axi_rvalid_o", {31'h0, rvalid_i}, {31'h0, rd_pend_q});
      end
      // Register responses must be OKAY
      if (bvalid_i && bready_i) begin
        compare("s_axi_bresp_o", {30'h0, bresp_i}, 32'h0);
      end
      if (rvalid_i && rready_i) begin
        compare("s_axi_rresp_o", {30'h0, rresp_i}, 32'h0);
        compare("s_axi_rdata_o", rdata_i, exp_rdata_i);
      end
      if (wr_take) begin
        wr_pend_q = 1'b1;
      end else if (bready_i) begin
        wr_pend_q = 1'b0;
      end
      if (rd_take) begin
        rd_pend_q = 1'b1;
      end else if (rready_i) begin
        rd_pend_q = 1'b0;
      end
      if (row_done_i) begin
        $display("Row %0d finished: %0d checks, %0d errors", row_idx_i,
                 chk_cnt_o - row_chk_q, err_cnt_o - row_err_q);
        row_chk_q = chk_cnt_o;
        row_err_q = err_cnt_o;
      end
      if (fin_i) begin
        if (exp_q.size() != 0) begin
          err_cnt_o = err_cnt_o + 1;
          $display("%0d expected output bytes never arrived", exp_q.size());
        end
        $display("Totals: %0d checks, %0d errors", chk_cnt_o, err_cnt_o);
      end
    end
  end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_frame_buf.sv
`timescale 1ns/100ps
`include "fb_macros.svh"

module tb_frame_buf
  import video_pkg::*;
();

  typedef enum logic [1:0] {
    REG_WR,
    REG_RD,
    CAM_FRM,
    PLAY
  } row_kind_e;

  // One line of the stimulus table
  typedef struct packed {
    row_kind_e                 kind;
    logic [`FB_AXI_ADDR_W-1:0] addr;
    logic [31:0]               data;   // write value, luma, or idle cycles before a frame
    logic [31:0]               expv;
    logic [15:0]               len;
    logic                      bp;
  } row_t;

  logic                      clk_board;
  logic                      rst_n_i;
  logic                      cam_vld_i;
  pix_t                      cam_data_i;
  logic                      cam_sof_i;
  logic                      cam_eof_i;
  logic [`FB_AXI_ADDR_W-1:0] s_axi_awaddr_i;
  logic                      s_axi_awvalid_i;
  logic                      s_axi_awready_o;
  logic [31:0]               s_axi_wdata_i;
  logic [3:0]                s_axi_wstrb_i;
  logic                      s_axi_wvalid_i;
  logic                      s_axi_wready_o;
  logic [1:0]                s_axi_bresp_o;
  logic                      s_axi_bvalid_o;
  logic                      s_axi_bready_i;
  logic [`FB_AXI_ADDR_W-1:0] s_axi_araddr_i;
  logic                      s_axi_arvalid_i;
  logic                      s_axi_arready_o;
  logic [31:0]               s_axi_rdata_o;
  logic [1:0]                s_axi_rresp_o;
  logic                      s_axi_rvalid_o;
  logic                      s_axi_rready_i;
  logic                      out_vld_o;
  logic                      out_rdy_i;
  pix_t                      out_data_o;
  logic                      out_sof_o;
  logic                      out_eof_o;

  logic        exp_push;
  logic [9:0]  exp_byte;
  logic [31:0] exp_rdata;
  logic        row_done;
  int          row_idx;
  logic        fin;
  int          err_cnt;
  int          chk_cnt;
  int          pend;

  row_t        rows[$];
  pix_t        frame_q[$];
  logic [31:0] rnd_q;
  logic        cap_en_q;
  int          budget = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk_board),
    .rst_n_o (rst_n_i)
  );

  frame_buf_top u_frame_buf_top (
    .clk_board       (clk_board),
    .rst_n_i         (rst_n_i),
    .cam_vld_i       (cam_vld_i),
    .cam_data_i      (cam_data_i),
    .cam_sof_i       (cam_sof_i),
    .cam_eof_i       (cam_eof_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .out_vld_o       (out_vld_o),
    .out_rdy_i       (out_rdy_i),
    .out_data_o      (out_data_o),
    .out_sof_o       (out_sof_o),
    .out_eof_o       (out_eof_o)
  );

  tb_checker u_checker (
    .clk_board   (clk_board),
    .rst_n_i     (rst_n_i),
    .out_vld_i   (out_vld_o),
    .out_rdy_i   (out_rdy_i),
    .out_data_i  (out_data_o),
    .out_sof_i   (out_sof_o),
    .out_eof_i   (out_eof_o),
    .awvalid_i   (s_axi_awvalid_i),
    .awready_i   (s_axi_awready_o),
    .wvalid_i    (s_axi_wvalid_i),
    .wready_i    (s_axi_wready_o),
    .arvalid_i   (s_axi_arvalid_i),
    .arready_i   (s_axi_arready_o),
    .bvalid_i    (s_axi_bvalid_o),
    .bready_i    (s_axi_bready_i),
    .bresp_i     (s_axi_bresp_o),
    .rvalid_i    (s_axi_rvalid_o),
    .rready_i    (s_axi_rready_i),
    .rresp_i     (s_axi_rresp_o),
    .rdata_i     (s_axi_rdata_o),
    .exp_push_i  (exp_push),
    .exp_byte_i  (exp_byte),
    .exp_rdata_i (exp_rdata),
    .row_done_i  (row_done),
    .row_idx_i   (row_idx),
    .fin_i       (fin),
    .err_cnt_o   (err_cnt),
    .chk_cnt_o   (chk_cnt),
    .pend_o      (pend)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input row_kind_e kind, input logic [`FB_AXI_ADDR_W-1:0] addr,
                         input logic [31:0] data, input logic [31:0] expv,
                         input int len, input logic bp);
    row_t r;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.expv = expv;
    r.len  = len[15:0];
    r.bp   = bp;
    rows.push_back(r);
  endtask

  //========================================
  // AXI4-Lite master tasks
  //========================================
  // Requests stay up until the response channel answers
  task automatic write_reg(input logic [`FB_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk_board);
    s_axi_awaddr_i  = addr;
    s_axi_awvalid_i = 1'b1;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = 4'hf;
    s_axi_wvalid_i  = 1'b1;
    @(negedge clk_board);
    while (!s_axi_bvalid_o) @(negedge clk_board);
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    // bready is always high, so bvalid drops at the next edge
    @(negedge clk_board);
  endtask

  task automatic read_reg(input logic [`FB_AXI_ADDR_W-1:0] addr, input logic [31:0] expv);
    @(negedge clk_board);
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    exp_rdata       = expv;
    @(negedge clk_board);
    while (!s_axi_rvalid_o) @(negedge clk_board);
    s_axi_arvalid_i = 1'b0;
    @(negedge clk_board);
  endtask

  // Camera frame of random bytes that becomes the reference when capture is on
  task automatic send_frame(input int len, input int lead);
    if (cap_en_q) begin
      frame_q.delete();
    end
    repeat (lead) @(negedge clk_board);
    for (int i = 0; i < len; i++) begin
      @(negedge clk_board);
      rnd_q      = xorshift32(rnd_q);
      cam_vld_i  = 1'b1;
      cam_data_i = rnd_q[7:0];
      cam_sof_i  = (i == 0);
      cam_eof_i  = (i == len - 1);
      if (cap_en_q) begin
        frame_q.push_back(rnd_q[7:0]);
      end
    end
    @(negedge clk_board);
    cam_vld_i = 1'b0;
    cam_sof_i = 1'b0;
    cam_eof_i = 1'b0;
  endtask

  task automatic run_playback(input pix_t luma, input logic bp);
    int   sum;
    int   last;
    pix_t sat;
    last = frame_q.size() - 1;
    foreach (frame_q[i]) begin
      // Offset added and clipped at full scale
      sum = int'(frame_q[i]) + int'(luma);
      sat = (sum > 255) ? 8'hff : sum[7:0];
      @(negedge clk_board);
      exp_push = 1'b1;
      exp_byte = {(i == 0), (i == last), sat};
    end
    @(negedge clk_board);
    exp_push = 1'b0;
    write_reg(`FB_REG_LUMA, {24'h0, luma});
    write_reg(`FB_REG_CTRL, {30'h0, 1'b1, cap_en_q});
    while (pend != 0) begin
      @(negedge clk_board);
      if (bp) begin
        rnd_q     = xorshift32(rnd_q);
        out_rdy_i = rnd_q[0];
      end
    end
    out_rdy_i = 1'b1;
  endtask

  initial begin
    cam_vld_i       = 1'b0;
    cam_data_i      = '0;
    cam_sof_i       = 1'b0;
    cam_eof_i       = 1'b0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b1;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b1;
    out_rdy_i       = 1'b1;
    exp_push        = 1'b0;
    exp_byte        = '0;
    exp_rdata       = '0;
    row_done        = 1'b0;
    row_idx         = 0;
    fin             = 1'b0;
    rnd_q           = 32'h9a06_052b;
    cap_en_q        = 1'b0;

    //========================================
    // Stimulus table
    //========================================
    add_row(REG_WR,  `FB_REG_LUMA,   32'h5a, 32'h0,  0,  1'b0);
    add_row(REG_RD,  `FB_REG_LUMA,   32'h0,  32'h5a, 0,  1'b0);
    add_row(REG_WR,  `FB_REG_CTRL,   32'h1,  32'h0,  0,  1'b0);
    add_row(REG_RD,  `FB_REG_CTRL,   32'h0,  32'h1,  0,  1'b0);
    add_row(REG_RD,  4'hc,           32'h0,  32'h0,  0,  1'b0);
    add_row(CAM_FRM, 4'h0,           32'd5,  32'h0,  37, 1'b0);
    // One frame counted with 37 bytes
    add_row(REG_RD,  `FB_REG_STATUS, 32'h0,  {5'h0, 11'd37, 16'd1}, 0, 1'b0);
    add_row(PLAY,    4'h0,           32'h0,  32'h0,  37, 1'b0);
    add_row(PLAY,    4'h0,           32'h60, 32'h0,  37, 1'b0);
    add_row(REG_WR,  `FB_REG_CTRL,   32'h0,  32'h0,  0,  1'b0);
    add_row(CAM_FRM, 4'h0,           32'd3,  32'h0,  20, 1'b0);
    add_row(REG_RD,  `FB_REG_STATUS, 32'h0,  {5'h0, 11'd37, 16'd1}, 0, 1'b0);
    add_row(PLAY,    4'h0,           32'h0,  32'h0,  37, 1'b0);
    add_row(PLAY,    4'h0,           32'h60, 32'h0,  37, 1'b1);

    foreach (rows[i]) begin
      budget = budget + 8 * int'(rows[i].len) + 200;
    end

    wait (rst_n_i);
    foreach (rows[i]) begin
      case (rows[i].kind)
        REG_WR: begin
          write_reg(rows[i].addr, rows[i].data);
          if (rows[i].addr == `FB_REG_CTRL) begin
            cap_en_q = rows[i].data[0];
          end
        end
        REG_RD:  read_reg(rows[i].addr, rows[i].expv);
        CAM_FRM: send_frame(int'(rows[i].len), int'(rows[i].data));
        PLAY:    run_playback(rows[i].data[7:0], rows[i].bp);
      endcase
      @(negedge clk_board);
      row_idx  = i;
      row_done = 1'b1;
      @(negedge clk_board);
      row_done = 1'b0;
    end

    fin = 1'b1;
    @(negedge clk_board);
    fin = 1'b0;
    @(negedge clk_board);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge clk_board);
    $display("Timeout: the run did not finish within %0d clock cycles", budget);
    $display("** FAIL **");
    $finish;
  end

endmodule
